// ==== rtl/cpu_backend_macros.svh ====
`ifndef CPU_BACKEND_MACROS_SVH
`define CPU_BACKEND_MACROS_SVH

// data path width, fixed by RV32I
`define XLEN 32

// data memory size in words
`define DMEM_WORDS 256

// pc value carried by a bubble record
`define NOP_PC 32'hFFFF_FFFC

`endif

// ==== rtl/cpu_backend_pkg.sv ====
`include "cpu_backend_macros.svh"

package cpu_backend_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       regaddr_t;

    // word index width into data memory
    localparam int DMEM_AW = $clog2(`DMEM_WORDS);
    typedef logic [DMEM_AW-1:0] dmem_addr_t;

    // encodings follow funct3 of the load and store opcodes
    typedef enum logic [2:0] {
        MA_SIZE_B  = 3'b000,
        MA_SIZE_H  = 3'b001,
        MA_SIZE_W  = 3'b010,
        MA_SIZE_BU = 3'b100,
        MA_SIZE_HU = 3'b101
    } ma_size_t;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_t;

    // record handed over by the execute stage
    typedef struct packed {
        word_t   pc;
        word_t   ir;
        mem_op_t mem_op;
        word_t   alu_result;  // also the effective address
        word_t   store_data;
        logic    wb_valid;
    } ex_mem_t;

    // memory to write-back pipeline register
    typedef struct packed {
        word_t      pc;
        word_t      ir;
        logic       load;
        ma_size_t   ma_size;
        logic [1:0] ma_alignment;
        word_t      wb_data;
        logic       wb_valid;
    } mem_wb_t;

    typedef struct packed {
        regaddr_t addr;
        word_t    data;
        logic     valid;
    } wb_write_t;

    typedef struct packed {
        dmem_addr_t addr;   // word index
        word_t      wdata;  // already in byte lanes
        logic [3:0] be;
        logic       we;
        logic       re;
    } dmem_req_t;

endpackage

// ==== rtl/stage_memory.sv ====
`timescale 1ns/10ps
`include "cpu_backend_macros.svh"

module stage_memory
    import cpu_backend_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  ex_mem_t   ex_i,
    output dmem_req_t dmem_req_o,
    output mem_wb_t   mem_wb_o
);

    ma_size_t   ma_size;
    logic [1:0] ma_alignment;
    logic       is_load;
    logic       is_store;
    logic [3:0] store_be;
    word_t      store_wdata;

    assign ma_size      = ma_size_t'(ex_i.ir[14:12]);  // funct3
    assign ma_alignment = ex_i.alu_result[1:0];
    assign is_load      = (ex_i.mem_op == MEM_LOAD);
    assign is_store     = (ex_i.mem_op == MEM_STORE);

    // byte lanes and replicated store data per access size
    always_comb begin
        store_be    = 4'b0000;
        store_wdata = ex_i.store_data;
        case (ma_size)
            MA_SIZE_B: begin
                store_be    = 4'b0001 << ma_alignment;
                store_wdata = {4{ex_i.store_data[7:0]}};
            end
            MA_SIZE_H: begin
                store_be    = 4'b0011 << ma_alignment;  // alignment is 0 or 2
                store_wdata = {2{ex_i.store_data[15:0]}};
            end
            MA_SIZE_W: begin
                store_be = 4'b1111;
            end
            default: begin
                // unsigned sizes are not legal for stores
                store_be = 4'b0000;
            end
        endcase
    end

    always_comb begin
        dmem_req_o.addr  = ex_i.alu_result[DMEM_AW+1:2];
        dmem_req_o.wdata = store_wdata;
        dmem_req_o.be    = is_store ? store_be : 4'b0000;
        dmem_req_o.we    = is_store;
        dmem_req_o.re    = is_load;
    end

    // pipeline register toward write-back, bubble out of reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wb_o.pc           <= `NOP_PC;
            mem_wb_o.ir           <= '0;
            mem_wb_o.load         <= 1'b0;
            mem_wb_o.ma_size      <= MA_SIZE_W;
            mem_wb_o.ma_alignment <= 2'b00;
            mem_wb_o.wb_data      <= '0;
            mem_wb_o.wb_valid     <= 1'b0;
        end else begin
            mem_wb_o.pc           <= ex_i.pc;
            mem_wb_o.ir           <= ex_i.ir;
            mem_wb_o.load         <= is_load;
            mem_wb_o.ma_size      <= ma_size;
            mem_wb_o.ma_alignment <= ma_alignment;
            mem_wb_o.wb_data      <= ex_i.alu_result;
            mem_wb_o.wb_valid     <= ex_i.wb_valid & ~is_store;  // stores never write rd
        end
    end

endmodule

// ==== rtl/data_memory.sv ====
`timescale 1ns/10ps
`include "cpu_backend_macros.svh"

module data_memory
    import cpu_backend_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  dmem_req_t req_i,
    output word_t     rdata_o
);

    word_t mem [`DMEM_WORDS];

    // byte-masked write
    always_ff @(posedge clk_i) begin
        if (req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.be[b]) begin
                    mem[req_i.addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // read word lines up with the memory to write-back register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (req_i.re) begin
            rdata_o <= mem[req_i.addr];
        end
    end

endmodule

// ==== rtl/stage_writeback.sv ====
`timescale 1ns/10ps
`include "cpu_backend_macros.svh"

module stage_writeback
    import cpu_backend_pkg::*;
(
    input  mem_wb_t   mem_wb_i,
    input  word_t     dmem_read_data_i,
    output wb_write_t wb_o,
    output logic      empty_o
);

    word_t aligned;
    word_t load_data;

    // bring the addressed byte or halfword down to bit 0
    assign aligned = dmem_read_data_i >> {mem_wb_i.ma_alignment, 3'b000};

    always_comb begin
        case (mem_wb_i.ma_size)
            MA_SIZE_B:  load_data = {{24{aligned[7]}}, aligned[7:0]};
            MA_SIZE_H:  load_data = {{16{aligned[15]}}, aligned[15:0]};
            MA_SIZE_BU: load_data = {24'b0, aligned[7:0]};
            MA_SIZE_HU: load_data = {16'b0, aligned[15:0]};
            default:    load_data = aligned;  // word
        endcase
    end

    assign empty_o = (mem_wb_i.pc == `NOP_PC);

    always_comb begin
        wb_o.addr  = mem_wb_i.ir[11:7];  // rd
        wb_o.data  = mem_wb_i.load ? load_data : mem_wb_i.wb_data;
        // a bubble never writes back
        wb_o.valid = mem_wb_i.wb_valid & ~empty_o;
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/10ps

module register_file
    import cpu_backend_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  wb_write_t wr_i,
    input  regaddr_t  rs_addr_i,
    output word_t     rs_data_o
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.valid && (wr_i.addr != 5'd0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // combinational read, x0 reads as zero
    assign rs_data_o = (rs_addr_i == 5'd0) ? '0 : regs[rs_addr_i];

endmodule

// ==== rtl/cpu_backend.sv ====
`timescale 1ns/10ps

module cpu_backend
    import cpu_backend_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  ex_mem_t   ex_i,
    input  regaddr_t  rs_addr_i,
    output word_t     rs_data_o,
    output wb_write_t wb_o,
    output logic      empty_o
);

    dmem_req_t dmem_req;
    mem_wb_t   mem_wb;
    word_t     dmem_rdata;

    // memory access and pipeline register
    stage_memory stage_memory_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ex_i       (ex_i),
        .dmem_req_o (dmem_req),
        .mem_wb_o   (mem_wb)
    );

    data_memory data_memory_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (dmem_req),
        .rdata_o (dmem_rdata)
    );

    // load alignment and register write
    stage_writeback stage_writeback_inst (
        .mem_wb_i         (mem_wb),
        .dmem_read_data_i (dmem_rdata),
        .wb_o             (wb_o),
        .empty_o          (empty_o)
    );

    register_file register_file_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_i      (wb_o),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o)
    );

endmodule

// ==== test/cpu_backend_sva.sv ====
`timescale 1ns/10ps
`include "cpu_backend_macros.svh"

module cpu_backend_sva
    import cpu_backend_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input ex_mem_t   ex_i,
    input wb_write_t wb_o,
    input logic      empty_o,
    input regaddr_t  rs_addr_i,
    input word_t     rs_data_o
);

    int unsigned failures = 0;  // assertion failures so far

    // pipeline register holds a bubble throughout reset
    wb_quiet_in_reset: assert property (
        @(posedge clk_i) !rst_n_i |-> !wb_o.valid
    ) else begin
        failures++;
        $error("write-back valid high during reset");
    end

    // a bubble shows up one cycle later as empty, never as a write
    bubble_goes_empty: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (ex_i.pc == `NOP_PC) |=> (empty_o && !wb_o.valid)
    ) else begin
        failures++;
        $error("bubble did not reach write-back as empty");
    end

    // a write aimed at x0 changes no register, so a steady read stays steady
    x0_write_dropped: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (wb_o.valid && (wb_o.addr == 5'd0)) ##1 $stable(rs_addr_i) |-> $stable(rs_data_o)
    ) else begin
        failures++;
        $error("write aimed at x0 changed a register");
    end

endmodule

bind cpu_backend cpu_backend_sva cpu_backend_sva_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ex_i      (ex_i),
    .wb_o      (wb_o),
    .empty_o   (empty_o),
    .rs_addr_i (rs_addr_i),
    .rs_data_o (rs_data_o)
);

// ==== test/cpu_backend_tb.sv ====
`timescale 1ns/10ps
`include "cpu_backend_macros.svh"

module cpu_backend_tb
    import cpu_backend_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 2;
    localparam int INIT_CYCLES     = `DMEM_WORDS;
    localparam int SWEEP_CYCLES    = 32;
    localparam int DIRECTED_CYCLES = 160;  // upper bound on the directed records
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TEST_CYCLES     = RESET_CYCLES + 1 + INIT_CYCLES + 2 * SWEEP_CYCLES
                                   + DIRECTED_CYCLES + RANDOM_CYCLES + 2;
    localparam int WATCHDOG_NS     = (TEST_CYCLES + 20) * CLK_PERIOD;

    // one expected write-back per driven record
    typedef struct packed {
        logic     valid;
        logic     empty;
        regaddr_t addr;
        word_t    data;
    } wb_expect_t;

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    ex_mem_t   ex_i;
    regaddr_t  rs_addr_i;
    word_t     rs_data_o;
    wb_write_t wb_o;
    logic      empty_o;

    logic [7:0] shadow_mem [1024];                 // byte view of data memory
    word_t      shadow_regs [32] = '{default: '0};
    wb_expect_t wb_q [$];

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    cpu_backend cpu_backend_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .ex_i      (ex_i),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o),
        .wb_o      (wb_o),
        .empty_o   (empty_o)
    );

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic ex_mem_t bubble_record();
        ex_mem_t rec;
        rec        = '0;
        rec.pc     = `NOP_PC;
        rec.mem_op = MEM_NONE;
        return rec;
    endfunction

    function automatic ex_mem_t make_record(input mem_op_t op, input logic [2:0] funct3,
                                            input regaddr_t rd, input word_t addr,
                                            input word_t data, input logic wb_valid);
        ex_mem_t rec;
        rec.pc = $urandom & 32'hFFFF_FFFC;
        if (rec.pc == `NOP_PC) begin
            rec.pc = '0;  // keep clear of the bubble marker
        end
        rec.ir         = $urandom;
        rec.ir[14:12]  = funct3;
        rec.ir[11:7]   = rd;
        rec.mem_op     = op;
        rec.alu_result = addr;
        rec.store_data = data;
        rec.wb_valid   = wb_valid;
        return rec;
    endfunction

    // pattern over the whole word index
    function automatic word_t fill_word(input int index);
        logic [7:0] a;
        a = index[7:0];
        return {a ^ 8'ha5, ~a, a, 8'h3c ^ {a[3:0], a[7:4]}};
    endfunction

    function automatic word_t align_addr(input word_t addr, input logic [2:0] funct3);
        word_t aligned;
        aligned = addr;
        if (funct3 == MA_SIZE_W) begin
            aligned[1:0] = 2'b00;
        end else if (funct3 == MA_SIZE_H || funct3 == MA_SIZE_HU) begin
            aligned[0] = 1'b0;
        end
        return aligned;
    endfunction

    function automatic ex_mem_t random_record();
        int unsigned kind;
        logic [2:0]  funct3;
        ex_mem_t     rec;
        kind = $urandom_range(9);
        if (kind == 0) begin
            rec = bubble_record();
        end else if (kind <= 3) begin
            case ($urandom_range(4))
                0:       funct3 = MA_SIZE_B;
                1:       funct3 = MA_SIZE_BU;
                2:       funct3 = MA_SIZE_H;
                3:       funct3 = MA_SIZE_HU;
                default: funct3 = MA_SIZE_W;
            endcase
            rec = make_record(MEM_LOAD, funct3, $urandom_range(31),
                              align_addr($urandom, funct3), $urandom, $urandom_range(9) != 0);
        end else if (kind <= 6) begin
            case ($urandom_range(2))
                0:       funct3 = MA_SIZE_B;
                1:       funct3 = MA_SIZE_H;
                default: funct3 = MA_SIZE_W;
            endcase
            rec = make_record(MEM_STORE, funct3, $urandom_range(31),
                              align_addr($urandom, funct3), $urandom, $urandom_range(1));
        end else begin
            rec = make_record(MEM_NONE, $urandom_range(7), $urandom_range(31),
                              $urandom, $urandom, $urandom_range(1));
        end
        return rec;
    endfunction

    // reference: byte-addressed load with RV32I extension rules
    function automatic word_t expected_wb(input ex_mem_t rec);
        logic [9:0] a;
        logic [7:0] b0;
        logic [7:0] b1;
        word_t      value;
        a  = rec.alu_result[9:0];
        b0 = shadow_mem[a];
        b1 = shadow_mem[a + 10'd1];
        if (rec.mem_op != MEM_LOAD) begin
            value = rec.alu_result;
        end else begin
            case (rec.ir[14:12])
                MA_SIZE_B:  value = {{24{b0[7]}}, b0};
                MA_SIZE_BU: value = {24'b0, b0};
                MA_SIZE_H:  value = {{16{b1[7]}}, b1, b0};
                MA_SIZE_HU: value = {16'b0, b1, b0};
                default:    value = {shadow_mem[a + 10'd3], shadow_mem[a + 10'd2], b1, b0};
            endcase
        end
        return value;
    endfunction

    function automatic void store_shadow(input ex_mem_t rec);
        logic [9:0] a;
        a = rec.alu_result[9:0];
        case (rec.ir[14:12])
            MA_SIZE_B: begin
                shadow_mem[a] = rec.store_data[7:0];
            end
            MA_SIZE_H: begin
                shadow_mem[a]         = rec.store_data[7:0];
                shadow_mem[a + 10'd1] = rec.store_data[15:8];
            end
            default: begin
                for (int b = 0; b < 4; b++) begin
                    shadow_mem[{a[9:2], 2'(b)}] = rec.store_data[b*8 +: 8];
                end
            end
        endcase
    endfunction

    task automatic drive_record(input ex_mem_t rec, input regaddr_t rd_sel);
        wb_expect_t e;
        @(posedge clk_i);
        ex_i      <= rec;
        rs_addr_i <= rd_sel;
        e.empty = (rec.pc == `NOP_PC);
        e.valid = rec.wb_valid && (rec.mem_op != MEM_STORE) && !e.empty;
        e.addr  = rec.ir[11:7];
        e.data  = expected_wb(rec);  // memory as seen before this record
        if (rec.mem_op == MEM_STORE) begin
            store_shadow(rec);
        end
        wb_q.push_back(e);
    endtask

    // compare at the falling edge, one record behind the driver
    initial begin
        wb_expect_t e;
        @(posedge rst_n_i);
        forever begin
            @(negedge clk_i);
            check_value("rs_data_o", shadow_regs[rs_addr_i], rs_data_o);
            if (wb_q.size() > 1) begin
                e = wb_q.pop_front();
                check_value("wb_o.valid", e.valid, wb_o.valid);
                check_value("empty_o", e.empty, empty_o);
                if (e.valid) begin
                    check_value("wb_o.addr", e.addr, wb_o.addr);
                    check_value("wb_o.data", e.data, wb_o.data);
                    if (e.addr != 5'd0) begin
                        shadow_regs[e.addr] = e.data;  // visible at the next read
                    end
                end
            end
        end
    end

    initial begin
        wait (cpu_backend_inst.cpu_backend_sva_inst.failures != 0);
        $display("An assertion in cpu_backend_sva failed at %0t", $time);
        $display("Result: FAILED");
        $fatal(1, "assertion failure");
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        word_t base;
        word_t data;
        int    i;
        int    a;
        void'($urandom(32'h08cb_2e7e));
        ex_i      = bubble_record();
        rs_addr_i = '0;
        rst_n_i   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("wb_o.valid", 32'd0, wb_o.valid);
        check_value("empty_o", 32'd1, empty_o);
        for (i = 0; i < SWEEP_CYCLES; i++) begin
            drive_record(bubble_record(), regaddr_t'(i));
        end
        // fill every word so no load returns unknown data
        for (i = 0; i < INIT_CYCLES; i++) begin
            drive_record(make_record(MEM_STORE, MA_SIZE_W, '0, i * 4, fill_word(i), 1'b0), '0);
        end
        // word store then word load of the same address
        base = $urandom & 32'h0000_03FC;
        data = $urandom;
        drive_record(make_record(MEM_STORE, MA_SIZE_W, 5'd3, base, data, 1'b1), 5'd5);
        drive_record(make_record(MEM_LOAD, MA_SIZE_W, 5'd5, base, $urandom, 1'b1), 5'd5);
        repeat (2) drive_record(bubble_record(), 5'd5);
        // sub-word loads at every legal alignment
        for (i = 0; i < 8; i++) begin
            base = $urandom & 32'h0000_03FC;
            drive_record(make_record(MEM_STORE, MA_SIZE_H, 5'd0, base, $urandom, 1'b0), 5'd1);
            drive_record(make_record(MEM_STORE, MA_SIZE_H, 5'd0, base + 2, $urandom, 1'b0), 5'd2);
            drive_record(make_record(MEM_STORE, MA_SIZE_B, 5'd0, base + $urandom_range(3),
                                     $urandom, 1'b0), 5'd3);
            for (a = 0; a < 4; a++) begin
                drive_record(make_record(MEM_LOAD, MA_SIZE_B, regaddr_t'(a + 1), base + a,
                                         $urandom, 1'b1), $urandom_range(31));
                drive_record(make_record(MEM_LOAD, MA_SIZE_BU, regaddr_t'(a + 5), base + a,
                                         $urandom, 1'b1), $urandom_range(31));
            end
            for (a = 0; a < 4; a += 2) begin
                drive_record(make_record(MEM_LOAD, MA_SIZE_H, regaddr_t'(a + 10), base + a,
                                         $urandom, 1'b1), $urandom_range(31));
                drive_record(make_record(MEM_LOAD, MA_SIZE_HU, regaddr_t'(a + 11), base + a,
                                         $urandom, 1'b1), $urandom_range(31));
            end
            drive_record(make_record(MEM_LOAD, MA_SIZE_W, 5'd15, base, $urandom, 1'b1), 5'd1);
        end
        // ALU result passes unchanged, store never writes rd
        data = $urandom;
        drive_record(make_record(MEM_NONE, $urandom_range(7), 5'd7, data, $urandom, 1'b1), 5'd7);
        drive_record(make_record(MEM_STORE, MA_SIZE_W, 5'd9, $urandom & 32'h0000_03FC,
                                 $urandom, 1'b1), 5'd9);
        repeat (2) drive_record(bubble_record(), 5'd7);
        drive_record(bubble_record(), 5'd9);
        // write aimed at x0 while x7 is read, then x0 read back after the write edge
        drive_record(make_record(MEM_NONE, $urandom_range(7), 5'd0, $urandom, $urandom, 1'b1),
                     5'd0);
        repeat (2) drive_record(bubble_record(), 5'd7);
        repeat (2) drive_record(bubble_record(), 5'd0);
        for (i = 0; i < RANDOM_CYCLES; i++) begin
            drive_record(random_record(), $urandom_range(31));
        end
        for (i = 0; i < SWEEP_CYCLES; i++) begin
            drive_record(bubble_record(), regaddr_t'(i));
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== cpu_backend.f ====
+incdir+rtl
rtl/cpu_backend_pkg.sv
rtl/stage_memory.sv
rtl/data_memory.sv
rtl/stage_writeback.sv
rtl/register_file.sv
rtl/cpu_backend.sv
test/cpu_backend_sva.sv
test/cpu_backend_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_backend

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_backend_pkg.sv
      - rtl/stage_memory.sv
      - rtl/data_memory.sv
      - rtl/stage_writeback.sv
      - rtl/register_file.sv
      - rtl/cpu_backend.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/cpu_backend_sva.sv
      - test/cpu_backend_tb.sv
